/* hw/bus_pkg.sv */
/*
  Peripheral bus package
  Address, data and access-size types of the shared bus, plus the
  region map used to steer accesses to the three slaves
*/
package bus_pkg;

  // Byte address and data word of the 32-bit bus
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;

  // Access size: 0 byte, 1 halfword, 2 word
  typedef logic [1:0] size_t;

  // ==========================================================
  // Region map
  // ==========================================================
  localparam addr_t RAM_BASE    = 32'h0000_0000;
  localparam addr_t TIMER_BASE  = 32'h0200_0000;
  localparam addr_t UART_BASE   = 32'h1000_0000;
  // Upper byte picks the region
  localparam addr_t REGION_MASK = 32'hFF00_0000;

  // Read value for addresses that hit no slave
  localparam data_t UNMAPPED_DATA = 32'h0000_0000;

endpackage

/* hw/periph_pkg.sv */
/*
  Peripheral register package
  Register offsets of the timer and the console, status bit positions
  and the serial byte type
*/
package periph_pkg;

  // Serial data byte
  typedef logic [7:0] byte_t;
  // Register offset within a region
  typedef logic [7:0] ofs_t;

  // Console registers
  localparam ofs_t UART_DATA_OFS = 8'h00;
  localparam ofs_t UART_STAT_OFS = 8'h04;
  localparam ofs_t UART_IE_OFS   = 8'h08;

  // Console status bit positions
  localparam int STAT_RX_VALID = 0;
  localparam int STAT_TX_FULL  = 1;
  localparam int STAT_TX_EMPTY = 2;

  // Timer registers
  localparam ofs_t TIMER_MTIME_OFS    = 8'h00;
  localparam ofs_t TIMER_MTIMECMP_OFS = 8'h04;
  localparam ofs_t TIMER_MSIP_OFS     = 8'h08;

endpackage

/* hw/bus_arbiter.sv */
/*
  Bus arbiter
  Round-robin grant of the shared peripheral bus to one of two masters,
  forwarding the owner's request and routing ready and read data back
*/
module bus_arbiter (
  input  logic            clk,
  input  logic            rst,
  // Master 0
  input  logic            m0_req_valid,
  input  bus_pkg::addr_t  m0_req_addr,
  input  bus_pkg::data_t  m0_req_wdata,
  input  logic            m0_req_we,
  input  bus_pkg::size_t  m0_req_size,
  output logic            m0_req_ready,
  output bus_pkg::data_t  m0_req_rdata,
  // Master 1
  input  logic            m1_req_valid,
  input  bus_pkg::addr_t  m1_req_addr,
  input  bus_pkg::data_t  m1_req_wdata,
  input  logic            m1_req_we,
  input  bus_pkg::size_t  m1_req_size,
  output logic            m1_req_ready,
  output bus_pkg::data_t  m1_req_rdata,
  // Shared bus towards the decoder
  output logic            bus_valid,
  output bus_pkg::addr_t  bus_addr,
  output bus_pkg::data_t  bus_wdata,
  output logic            bus_we,
  output bus_pkg::size_t  bus_size,
  input  logic            bus_ready,
  input  bus_pkg::data_t  bus_rdata
);

  typedef enum logic [1:0] {IDLE, OWN_M0, OWN_M1} arb_state_t;

  arb_state_t state;
  // High when m1 held the bus last
  logic       last_m1;
  logic       pick_m1;
  logic       done;

  // m1 wins when alone, or on a tie when m0 was served last
  assign pick_m1 = m1_req_valid && (!m0_req_valid || !last_m1);
  assign done    = bus_valid && bus_ready;

  // ==========================================================
  // Grant FSM
  // ==========================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= IDLE;
      // Favor m0 on the first tie
      last_m1 <= 1'b1;
    end else begin
      case (state)
        IDLE: begin
          if (pick_m1) begin
            state   <= OWN_M1;
            last_m1 <= 1'b1;
          end else if (m0_req_valid) begin
            state   <= OWN_M0;
            last_m1 <= 1'b0;
          end
        end
        OWN_M0, OWN_M1: begin
          // Grant held until the transfer completes
          if (done) begin
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Request mux, owner's fields onto the bus
  always_comb begin
    bus_valid = 1'b0;
    bus_addr  = m0_req_addr;
    bus_wdata = m0_req_wdata;
    bus_we    = m0_req_we;
    bus_size  = m0_req_size;
    if (state == OWN_M0) begin
      bus_valid = m0_req_valid;
    end else if (state == OWN_M1) begin
      bus_valid = m1_req_valid;
      bus_addr  = m1_req_addr;
      bus_wdata = m1_req_wdata;
      bus_we    = m1_req_we;
      bus_size  = m1_req_size;
    end
  end

  // Response back to the owner only
  assign m0_req_ready = (state == OWN_M0) && bus_ready;
  assign m1_req_ready = (state == OWN_M1) && bus_ready;
  assign m0_req_rdata = (state == OWN_M0) ? bus_rdata : '0;
  assign m1_req_rdata = (state == OWN_M1) ? bus_rdata : '0;

endmodule

/* hw/bus_decoder.sv */
/*
  Bus address decoder
  Selects the RAM, timer or console from the upper address bits, muxes
  the selected slave's response and answers unmapped accesses itself
*/
module bus_decoder #(
  parameter int RAM_WORDS = 256
) (
  input  logic            bus_valid,
  input  bus_pkg::addr_t  bus_addr,
  input  logic            bus_we,
  output logic            bus_ready,
  output bus_pkg::data_t  bus_rdata,
  // Slave selects
  output logic            ram_valid,
  output logic            tmr_valid,
  output logic            uart_valid,
  // Slave responses
  input  logic            ram_ready,
  input  bus_pkg::data_t  ram_rdata,
  input  logic            tmr_ready,
  input  bus_pkg::data_t  tmr_rdata,
  input  logic            uart_ready,
  input  bus_pkg::data_t  uart_rdata
);

  import bus_pkg::*;

  addr_t region;
  logic  ram_hit;
  logic  tmr_hit;
  logic  uart_hit;
  data_t sel_rdata;

  // Region match on the upper byte
  assign region   = bus_addr & REGION_MASK;
  // RAM past its last word is treated as unmapped
  assign ram_hit  = (region == RAM_BASE) && (bus_addr[23:2] < RAM_WORDS);
  assign tmr_hit  = (region == TIMER_BASE);
  assign uart_hit = (region == UART_BASE);

  assign ram_valid  = bus_valid && ram_hit;
  assign tmr_valid  = bus_valid && tmr_hit;
  assign uart_valid = bus_valid && uart_hit;

  always_comb begin
    if (ram_hit) begin
      bus_ready = ram_ready;
      sel_rdata = ram_rdata;
    end else if (tmr_hit) begin
      bus_ready = tmr_ready;
      sel_rdata = tmr_rdata;
    end else if (uart_hit) begin
      bus_ready = uart_ready;
      sel_rdata = uart_rdata;
    end else begin
      // Unmapped: same-cycle answer, writes dropped
      bus_ready = bus_valid;
      sel_rdata = UNMAPPED_DATA;
    end
    // Read data only carries meaning on reads
    bus_rdata = bus_we ? '0 : sel_rdata;
  end

endmodule

/* hw/clint_timer.sv */
/*
  Core-local timer
  Free-running mtime with a writable compare register raising mtip,
  and a software interrupt bit driving msip
*/
module clint_timer (
  input  logic            clk,
  input  logic            rst,
  input  logic            tmr_valid,
  input  bus_pkg::addr_t  bus_addr,
  input  bus_pkg::data_t  bus_wdata,
  input  logic            bus_we,
  output logic            tmr_ready,
  output bus_pkg::data_t  tmr_rdata,
  output logic            mtip,
  output logic            msip
);

  import bus_pkg::*;
  import periph_pkg::*;

  data_t mtime;
  data_t mtimecmp;
  logic  msip_bit;
  ofs_t  ofs;
  logic  wr_en;

  assign ofs   = bus_addr[7:0];
  assign wr_en = tmr_valid && bus_we;
  // Register access always completes in one cycle
  assign tmr_ready = tmr_valid;

  // ==========================================================
  // Registers
  // ==========================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      mtime <= '0;
    end else if (wr_en && (ofs == TIMER_MTIME_OFS)) begin
      mtime <= bus_wdata;
    end else begin
      mtime <= mtime + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      // All ones keeps mtip quiet after reset
      mtimecmp <= '1;
      msip_bit <= 1'b0;
    end else if (wr_en) begin
      if (ofs == TIMER_MTIMECMP_OFS) begin
        mtimecmp <= bus_wdata;
      end
      if (ofs == TIMER_MSIP_OFS) begin
        msip_bit <= bus_wdata[0];
      end
    end
  end

  // Unsigned compare, registered
  always_ff @(posedge clk) begin
    if (rst) begin
      mtip <= 1'b0;
    end else begin
      mtip <= (mtime >= mtimecmp);
    end
  end

  assign msip = msip_bit;

  // Read mux
  always_comb begin
    case (ofs)
      TIMER_MTIME_OFS:    tmr_rdata = mtime;
      TIMER_MTIMECMP_OFS: tmr_rdata = mtimecmp;
      TIMER_MSIP_OFS:     tmr_rdata = {{31{1'b0}}, msip_bit};
      default:            tmr_rdata = '0;
    endcase
  end

endmodule

/* hw/uart_console.sv */
/*
  Console port
  Transmit FIFO drained by tx_valid/tx_ready, single-byte receive
  holding register, status and interrupt-enable registers
*/
module uart_console #(
  parameter int TX_FIFO_DEPTH = 4
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               uart_valid,
  input  bus_pkg::addr_t     bus_addr,
  input  bus_pkg::data_t     bus_wdata,
  input  logic               bus_we,
  output logic               uart_ready,
  output bus_pkg::data_t     uart_rdata,
  // Serial side
  output logic               tx_valid,
  output periph_pkg::byte_t  tx_data,
  input  logic               tx_ready,
  input  logic               rx_valid,
  input  periph_pkg::byte_t  rx_data,
  output logic               rx_ready,
  output logic               uart_irq
);

  import bus_pkg::*;
  import periph_pkg::*;

  localparam int PTR_W = (TX_FIFO_DEPTH > 1) ? $clog2(TX_FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(TX_FIFO_DEPTH + 1);

  byte_t            tx_mem [TX_FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] tx_count;
  logic             tx_full;
  logic             tx_empty;
  logic             tx_push;
  logic             tx_pop;
  byte_t            rx_hold;
  logic             rx_full;
  logic             irq_en;
  ofs_t             ofs;
  logic             data_wr;
  logic             data_rd;

  assign ofs     = bus_addr[7:0];
  assign data_wr = uart_valid && bus_we && (ofs == UART_DATA_OFS);
  assign data_rd = uart_valid && !bus_we && (ofs == UART_DATA_OFS);

  // Stall a data write while the FIFO is full
  assign uart_ready = uart_valid && !(data_wr && tx_full);

  // ==========================================================
  // Transmit FIFO
  // ==========================================================
  assign tx_full  = (tx_count == CNT_W'(TX_FIFO_DEPTH));
  assign tx_empty = (tx_count == '0);
  assign tx_push  = data_wr && !tx_full;
  assign tx_pop   = tx_valid && tx_ready;
  assign tx_valid = !tx_empty;
  assign tx_data  = tx_mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (tx_push) begin
      tx_mem[wr_ptr] <= bus_wdata[7:0];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      tx_count <= '0;
    end else begin
      if (tx_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(TX_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (tx_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(TX_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Count tracks push and pop in the same cycle
      if (tx_push && !tx_pop) begin
        tx_count <= tx_count + 1'b1;
      end else if (tx_pop && !tx_push) begin
        tx_count <= tx_count - 1'b1;
      end
    end
  end

  // ==========================================================
  // Receive holding register and interrupt enable
  // ==========================================================
  assign rx_ready = !rx_full;
  assign uart_irq = rx_full && irq_en;

  always_ff @(posedge clk) begin
    if (rx_valid && rx_ready) begin
      rx_hold <= rx_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rx_full <= 1'b0;
      irq_en  <= 1'b0;
    end else begin
      if (rx_valid && rx_ready) begin
        rx_full <= 1'b1;
      end else if (data_rd) begin
        // Reading the data register frees the holding register
        rx_full <= 1'b0;
      end
      if (uart_valid && bus_we && (ofs == UART_IE_OFS)) begin
        irq_en <= bus_wdata[0];
      end
    end
  end

  // Read mux
  always_comb begin
    uart_rdata = '0;
    case (ofs)
      UART_DATA_OFS: begin
        if (rx_full) begin
          uart_rdata[7:0] = rx_hold;
        end
      end
      UART_STAT_OFS: begin
        uart_rdata[STAT_RX_VALID] = rx_full;
        uart_rdata[STAT_TX_FULL]  = tx_full;
        uart_rdata[STAT_TX_EMPTY] = tx_empty;
      end
      UART_IE_OFS: uart_rdata[0] = irq_en;
      default:     uart_rdata = '0;
    endcase
  end

endmodule

/* hw/data_ram.sv */
/*
  Data RAM
  Word-organized memory with byte-lane writes from size and low
  address bits, and a registered read one cycle after valid
*/
module data_ram #(
  parameter int RAM_WORDS = 256
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            ram_valid,
  input  bus_pkg::addr_t  bus_addr,
  input  bus_pkg::data_t  bus_wdata,
  input  logic            bus_we,
  input  bus_pkg::size_t  bus_size,
  output logic            ram_ready,
  output bus_pkg::data_t  ram_rdata
);

  import bus_pkg::*;

  localparam int IDX_W = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

  data_t            mem [RAM_WORDS];
  logic [IDX_W-1:0] idx;
  logic [3:0]       lane_en;
  data_t            lane_data;
  logic             access;

  assign idx = bus_addr[IDX_W+1:2];
  // One access per request, ready pending blocks a repeat
  assign access = ram_valid && !ram_ready;

  // Lane enables and replicated write data
  always_comb begin
    case (bus_size)
      2'd0: begin
        lane_en   = 4'b0001 << bus_addr[1:0];
        lane_data = {4{bus_wdata[7:0]}};
      end
      2'd1: begin
        lane_en   = bus_addr[1] ? 4'b1100 : 4'b0011;
        lane_data = {2{bus_wdata[15:0]}};
      end
      default: begin
        lane_en   = 4'b1111;
        lane_data = bus_wdata;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (access) begin
      if (bus_we) begin
        for (int i = 0; i < 4; i++) begin
          if (lane_en[i]) begin
            mem[idx][8*i +: 8] <= lane_data[8*i +: 8];
          end
        end
      end
      // Whole aligned word back
      ram_rdata <= mem[idx];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ram_ready <= 1'b0;
    end else begin
      ram_ready <= access;
    end
  end

endmodule

/* hw/periph_soc.sv */
/*
  Peripheral subsystem top level
  Two masters share one bus through the arbiter and reach the RAM,
  timer and console through the address decoder
*/
module periph_soc #(
  parameter int RAM_WORDS     = 256,
  parameter int TX_FIFO_DEPTH = 4
) (
  input  logic               clk,
  input  logic               rst,
  // Master 0, core data port
  input  logic               m0_req_valid,
  input  bus_pkg::addr_t     m0_req_addr,
  input  bus_pkg::data_t     m0_req_wdata,
  input  logic               m0_req_we,
  input  bus_pkg::size_t     m0_req_size,
  output logic               m0_req_ready,
  output bus_pkg::data_t     m0_req_rdata,
  // Master 1, second agent
  input  logic               m1_req_valid,
  input  bus_pkg::addr_t     m1_req_addr,
  input  bus_pkg::data_t     m1_req_wdata,
  input  logic               m1_req_we,
  input  bus_pkg::size_t     m1_req_size,
  output logic               m1_req_ready,
  output bus_pkg::data_t     m1_req_rdata,
  // Serial console
  output logic               tx_valid,
  output periph_pkg::byte_t  tx_data,
  input  logic               tx_ready,
  input  logic               rx_valid,
  input  periph_pkg::byte_t  rx_data,
  output logic               rx_ready,
  // Interrupts
  output logic               mtip,
  output logic               msip,
  output logic               uart_irq
);

  import bus_pkg::*;

  // Shared bus
  logic  bus_valid, bus_we, bus_ready;
  addr_t bus_addr;
  data_t bus_wdata, bus_rdata;
  size_t bus_size;

  // Slave selects and responses
  logic  ram_valid, ram_ready;
  logic  tmr_valid, tmr_ready;
  logic  uart_valid, uart_ready;
  data_t ram_rdata, tmr_rdata, uart_rdata;

  // ==========================================================
  // Arbitration and decode
  // ==========================================================
  bus_arbiter u_arbiter (
    .clk(clk), .rst(rst),
    .m0_req_valid(m0_req_valid), .m0_req_addr(m0_req_addr),
    .m0_req_wdata(m0_req_wdata), .m0_req_we(m0_req_we), .m0_req_size(m0_req_size),
    .m0_req_ready(m0_req_ready), .m0_req_rdata(m0_req_rdata),
    .m1_req_valid(m1_req_valid), .m1_req_addr(m1_req_addr),
    .m1_req_wdata(m1_req_wdata), .m1_req_we(m1_req_we), .m1_req_size(m1_req_size),
    .m1_req_ready(m1_req_ready), .m1_req_rdata(m1_req_rdata),
    .bus_valid(bus_valid), .bus_addr(bus_addr), .bus_wdata(bus_wdata),
    .bus_we(bus_we), .bus_size(bus_size),
    .bus_ready(bus_ready), .bus_rdata(bus_rdata)
  );

  bus_decoder #(.RAM_WORDS(RAM_WORDS)) u_decoder (
    .bus_valid(bus_valid), .bus_addr(bus_addr), .bus_we(bus_we),
    .bus_ready(bus_ready), .bus_rdata(bus_rdata),
    .ram_valid(ram_valid), .tmr_valid(tmr_valid), .uart_valid(uart_valid),
    .ram_ready(ram_ready), .ram_rdata(ram_rdata),
    .tmr_ready(tmr_ready), .tmr_rdata(tmr_rdata),
    .uart_ready(uart_ready), .uart_rdata(uart_rdata)
  );

  // ==========================================================
  // Slaves
  // ==========================================================
  clint_timer u_timer (
    .clk(clk), .rst(rst), .tmr_valid(tmr_valid),
    .bus_addr(bus_addr), .bus_wdata(bus_wdata), .bus_we(bus_we),
    .tmr_ready(tmr_ready), .tmr_rdata(tmr_rdata),
    .mtip(mtip), .msip(msip)
  );

  uart_console #(.TX_FIFO_DEPTH(TX_FIFO_DEPTH)) u_uart (
    .clk(clk), .rst(rst), .uart_valid(uart_valid),
    .bus_addr(bus_addr), .bus_wdata(bus_wdata), .bus_we(bus_we),
    .uart_ready(uart_ready), .uart_rdata(uart_rdata),
    .tx_valid(tx_valid), .tx_data(tx_data), .tx_ready(tx_ready),
    .rx_valid(rx_valid), .rx_data(rx_data), .rx_ready(rx_ready),
    .uart_irq(uart_irq)
  );

  data_ram #(.RAM_WORDS(RAM_WORDS)) u_ram (
    .clk(clk), .rst(rst), .ram_valid(ram_valid),
    .bus_addr(bus_addr), .bus_wdata(bus_wdata), .bus_we(bus_we),
    .bus_size(bus_size), .ram_ready(ram_ready), .ram_rdata(ram_rdata)
  );

endmodule

/* verification/periph_soc_assert.sv */
/*
  Arbiter assertions
  Grant exclusivity, turn order and request hold rules on the shared bus
*/
module periph_soc_assert (
  input logic           clk,
  input logic           rst,
  input logic           m0_req_valid,
  input logic           m0_req_ready,
  input logic           m1_req_valid,
  input logic           m1_req_ready,
  input logic           bus_valid,
  input bus_pkg::addr_t bus_addr,
  input logic           bus_ready
);

  timeunit 1ns;
  timeprecision 1ps;

  // Set while a master waits behind a transfer of the other one
  logic m0_passed;
  logic m1_passed;

  always_ff @(posedge clk) begin
    if (rst) begin
      m0_passed <= 1'b0;
      m1_passed <= 1'b0;
    end else begin
      if (m1_req_ready && m0_req_valid) begin
        m0_passed <= 1'b1;
      end else if (m0_req_ready || !m0_req_valid) begin
        m0_passed <= 1'b0;
      end
      if (m0_req_ready && m1_req_valid) begin
        m1_passed <= 1'b1;
      end else if (m1_req_ready || !m1_req_valid) begin
        m1_passed <= 1'b0;
      end
    end
  end

  // One ready per cycle, and a passed-over master goes next
  ready_exclusive: assert property (@(posedge clk) disable iff (rst)
    !(m0_req_ready && m1_req_ready) && !(m1_req_ready && m0_passed)
      && !(m0_req_ready && m1_passed))
    else $error("ready given to both masters or out of turn");

  // Request held stable until accepted
  bus_hold: assert property (@(posedge clk) disable iff (rst)
    (bus_valid && !bus_ready) |=> (bus_valid && $stable(bus_addr)))
    else $error("bus request dropped or changed before ready");

  // No ready without a request
  m0_ready_valid: assert property (@(posedge clk) disable iff (rst)
    m0_req_ready |-> m0_req_valid)
    else $error("m0 ready without valid");
  m1_ready_valid: assert property (@(posedge clk) disable iff (rst)
    m1_req_ready |-> m1_req_valid)
    else $error("m1 ready without valid");
  bus_ready_valid: assert property (@(posedge clk) disable iff (rst)
    bus_ready |-> bus_valid)
    else $error("bus ready without valid");

endmodule

bind bus_arbiter periph_soc_assert u_assert (
  .clk(clk),
  .rst(rst),
  .m0_req_valid(m0_req_valid),
  .m0_req_ready(m0_req_ready),
  .m1_req_valid(m1_req_valid),
  .m1_req_ready(m1_req_ready),
  .bus_valid(bus_valid),
  .bus_addr(bus_addr),
  .bus_ready(bus_ready)
);

/* verification/tb_periph_soc.sv */
/*
  Peripheral subsystem testbench
  Directed tests of RAM, arbitration, timer, console and unmapped
  accesses through the two master ports of the top level
*/
module tb_periph_soc;

  timeunit 1ns;
  timeprecision 1ps;

  import bus_pkg::*;
  import periph_pkg::*;

  localparam int RAM_WORDS     = 256;
  localparam int TX_FIFO_DEPTH = 4;
  // Cycles allowed for any single wait
  localparam int TIMEOUT       = 200;

  logic  clk, rst;
  logic  m0_req_valid, m0_req_we, m0_req_ready;
  addr_t m0_req_addr;
  data_t m0_req_wdata, m0_req_rdata;
  size_t m0_req_size;
  logic  m1_req_valid, m1_req_we, m1_req_ready;
  addr_t m1_req_addr;
  data_t m1_req_wdata, m1_req_rdata;
  size_t m1_req_size;
  logic  tx_valid, tx_ready, rx_valid, rx_ready;
  byte_t tx_data, rx_data;
  logic  mtip, msip, uart_irq;

  int    seed = 9183;
  int    n_checks;
  int    n_errors;
  // Expected RAM words, indexed by word
  data_t exp_mem [0:15];
  data_t rd0, rd1, wd;
  time   t0, t1;
  byte_t tx_exp [$];
  byte_t tx_got [$];
  logic  stall_done;

  periph_soc #(.RAM_WORDS(RAM_WORDS), .TX_FIFO_DEPTH(TX_FIFO_DEPTH)) u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Bytes leaving the console, sampled mid-cycle
  always @(negedge clk) begin
    if (tx_valid && tx_ready) begin
      tx_got.push_back(tx_data);
    end
  end

  // ==========================================================
  // Check and bus tasks
  // ==========================================================
  task automatic check_value(input string name, input data_t got, input data_t exp);
    n_checks++;
    if (got !== exp) begin
      $display("error %s got 0x%08h exp 0x%08h", name, got, exp);
      n_errors++;
    end
  endtask

  // One transfer on master m, entered and left 1 ns after a rising edge
  task automatic bus_access(input int m, input logic we, input addr_t addr,
                            input data_t wdata, input size_t size, output data_t rdata);
    int   cycles;
    logic got;
    cycles = 0;
    got    = 1'b0;
    rdata  = '0;
    if (m == 0) begin
      m0_req_valid = 1'b1;
      m0_req_we    = we;
      m0_req_addr  = addr;
      m0_req_wdata = wdata;
      m0_req_size  = size;
    end else begin
      m1_req_valid = 1'b1;
      m1_req_we    = we;
      m1_req_addr  = addr;
      m1_req_wdata = wdata;
      m1_req_size  = size;
    end
    // Ready seen mid-cycle completes on the next rising edge
    while (!got && cycles < TIMEOUT) begin
      @(negedge clk);
      if (m == 0 && m0_req_ready) begin
        got   = 1'b1;
        rdata = m0_req_rdata;
      end else if (m == 1 && m1_req_ready) begin
        got   = 1'b1;
        rdata = m1_req_rdata;
      end
      cycles++;
    end
    @(posedge clk);
    #1;
    if (m == 0) begin
      m0_req_valid = 1'b0;
    end else begin
      m1_req_valid = 1'b0;
    end
    if (!got) begin
      $display("timeout: master %0d never saw req_ready for address 0x%08h", m, addr);
      n_errors++;
    end
  endtask

  task automatic bus_write(input int m, input addr_t addr, input data_t wdata,
                           input size_t size);
    data_t unused;
    bus_access(m, 1'b1, addr, wdata, size, unused);
  endtask

  task automatic bus_read(input int m, input addr_t addr, output data_t rdata);
    bus_access(m, 1'b0, addr, '0, 2'd2, rdata);
  endtask

  // Offer one byte on the receive side until it is taken
  task automatic send_rx_byte(input byte_t b);
    int   cycles;
    logic got;
    cycles   = 0;
    got      = 1'b0;
    rx_valid = 1'b1;
    rx_data  = b;
    while (!got && cycles < TIMEOUT) begin
      @(negedge clk);
      got = rx_ready;
      cycles++;
    end
    @(posedge clk);
    #1;
    rx_valid = 1'b0;
    if (!got) begin
      $display("timeout: console never accepted the receive byte");
      n_errors++;
    end
  endtask

  // ==========================================================
  // Tests
  // ==========================================================
  task automatic test_arbitration();
    exp_mem[10] = $random(seed);
    exp_mem[11] = $random(seed);
    // Preload through m1 so the pointer still favors m0
    bus_write(1, RAM_BASE + 40, exp_mem[10], 2'd2);
    bus_write(1, RAM_BASE + 44, exp_mem[11], 2'd2);
    fork
      begin
        bus_read(0, RAM_BASE + 40, rd0);
        t0 = $time;
      end
      begin
        bus_read(1, RAM_BASE + 44, rd1);
        t1 = $time;
      end
    join
    check_value("m0_req_rdata", rd0, exp_mem[10]);
    check_value("m1_req_rdata", rd1, exp_mem[11]);
    check_value("m0_first", data_t'(t0 < t1), 1);
    // m0 alone, so the next tie goes to m1
    bus_read(0, RAM_BASE + 40, rd0);
    fork
      begin
        bus_read(0, RAM_BASE + 44, rd0);
        t0 = $time;
      end
      begin
        bus_read(1, RAM_BASE + 40, rd1);
        t1 = $time;
      end
    join
    check_value("m0_req_rdata", rd0, exp_mem[11]);
    check_value("m1_req_rdata", rd1, exp_mem[10]);
    check_value("m1_first", data_t'(t1 < t0), 1);
  endtask

  task automatic test_ram();
    for (int i = 0; i < 8; i++) begin
      exp_mem[i] = $random(seed);
      bus_write(0, RAM_BASE + 4 * i, exp_mem[i], 2'd2);
    end
    for (int i = 0; i < 8; i++) begin
      bus_read(1, RAM_BASE + 4 * i, rd1);
      check_value("m1_req_rdata", rd1, exp_mem[i]);
    end
    // Upper halfword of word 2, lower halfword of word 4, byte 1 of word 3
    wd = $random(seed);
    bus_write(0, RAM_BASE + 10, wd, 2'd1);
    exp_mem[2][31:16] = wd[15:0];
    wd = $random(seed);
    bus_write(0, RAM_BASE + 16, wd, 2'd1);
    exp_mem[4][15:0] = wd[15:0];
    wd = $random(seed);
    bus_write(0, RAM_BASE + 13, wd, 2'd0);
    exp_mem[3][15:8] = wd[7:0];
    for (int i = 2; i < 5; i++) begin
      bus_read(1, RAM_BASE + 4 * i, rd1);
      check_value("m1_req_rdata", rd1, exp_mem[i]);
    end
  endtask

  task automatic test_timer();
    int cycles;
    bus_read(0, TIMER_BASE + TIMER_MTIME_OFS, rd0);
    bus_read(0, TIMER_BASE + TIMER_MTIME_OFS, rd1);
    check_value("mtime_increases", data_t'(rd1 > rd0), 1);
    check_value("mtip", mtip, 0);
    bus_write(0, TIMER_BASE + TIMER_MTIMECMP_OFS, rd1 + 20, 2'd2);
    cycles = 0;
    while (!mtip && cycles < TIMEOUT) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (!mtip) begin
      $display("mtip did not rise after mtimecmp was set near mtime");
      n_errors++;
    end
    bus_write(1, TIMER_BASE + TIMER_MTIMECMP_OFS, 32'hFFFF_FFFF, 2'd2);
    cycles = 0;
    while (mtip && cycles < TIMEOUT) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    check_value("mtip", mtip, 0);
    // Software interrupt bit
    bus_write(0, TIMER_BASE + TIMER_MSIP_OFS, 32'h1, 2'd2);
    check_value("msip", msip, 1);
    bus_write(0, TIMER_BASE + TIMER_MSIP_OFS, 32'h0, 2'd2);
    check_value("msip", msip, 0);
  endtask

  task automatic test_console_tx();
    byte_t b;
    tx_ready = 1'b0;
    for (int i = 0; i < TX_FIFO_DEPTH; i++) begin
      b = $random(seed);
      tx_exp.push_back(b);
      bus_write(0, UART_BASE + UART_DATA_OFS, {24'h0, b}, 2'd2);
    end
    bus_read(1, UART_BASE + UART_STAT_OFS, rd1);
    check_value("stat_tx_full", rd1[STAT_TX_FULL], 1);
    check_value("stat_tx_empty", rd1[STAT_TX_EMPTY], 0);
    // Extra byte stalls until the serial side drains
    b = $random(seed);
    tx_exp.push_back(b);
    stall_done = 1'b0;
    fork
      begin
        bus_write(0, UART_BASE + UART_DATA_OFS, {24'h0, b}, 2'd2);
        stall_done = 1'b1;
      end
      begin
        repeat (8) @(posedge clk);
        #1;
        check_value("m0_req_ready_while_full", stall_done, 0);
        tx_ready = 1'b1;
      end
    join
    for (int c = 0; tx_valid && c < TIMEOUT; c++) begin
      @(posedge clk);
      #1;
    end
    check_value("tx_byte_count", tx_got.size(), TX_FIFO_DEPTH + 1);
    if (tx_got.size() == tx_exp.size()) begin
      foreach (tx_exp[i]) begin
        check_value("tx_data", tx_got[i], tx_exp[i]);
      end
    end
  endtask

  task automatic test_console_rx();
    byte_t b;
    b = $random(seed);
    send_rx_byte(b);
    check_value("rx_ready", rx_ready, 0);
    bus_read(0, UART_BASE + UART_STAT_OFS, rd0);
    check_value("stat_rx_valid", rd0[STAT_RX_VALID], 1);
    // Interrupt waits for the enable
    check_value("uart_irq", uart_irq, 0);
    bus_write(1, UART_BASE + UART_IE_OFS, 32'h1, 2'd2);
    check_value("uart_irq", uart_irq, 1);
    bus_read(0, UART_BASE + UART_DATA_OFS, rd0);
    check_value("uart_data", rd0, {24'h0, b});
    check_value("uart_irq", uart_irq, 0);
    check_value("rx_ready", rx_ready, 1);
  endtask

  task automatic test_unmapped();
    bus_read(0, 32'h2000_0000, rd0);
    check_value("unmapped_rdata", rd0, UNMAPPED_DATA);
    bus_read(1, RAM_BASE + 4 * RAM_WORDS, rd1);
    check_value("past_ram_rdata", rd1, UNMAPPED_DATA);
    // Writes there must not land in the RAM
    bus_write(0, 32'h2000_0000, $random(seed), 2'd2);
    bus_write(1, RAM_BASE + 4 * RAM_WORDS, $random(seed), 2'd2);
    bus_read(0, RAM_BASE, rd0);
    check_value("ram_word0", rd0, exp_mem[0]);
  endtask

  // ==========================================================
  // Sequence
  // ==========================================================
  initial begin
    n_checks     = 0;
    n_errors     = 0;
    rst          = 1'b1;
    m0_req_valid = 1'b0;
    m0_req_addr  = '0;
    m0_req_wdata = '0;
    m0_req_we    = 1'b0;
    m0_req_size  = 2'd2;
    m1_req_valid = 1'b0;
    m1_req_addr  = '0;
    m1_req_wdata = '0;
    m1_req_we    = 1'b0;
    m1_req_size  = 2'd2;
    tx_ready     = 1'b0;
    rx_valid     = 1'b0;
    rx_data      = '0;
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    // Reset values
    check_value("rx_ready", rx_ready, 1);
    check_value("tx_valid", tx_valid, 0);
    check_value("m0_req_ready", m0_req_ready, 0);
    check_value("m1_req_ready", m1_req_ready, 0);
    check_value("mtip", mtip, 0);
    check_value("msip", msip, 0);
    check_value("uart_irq", uart_irq, 0);
    test_arbitration();
    test_ram();
    test_timer();
    test_console_tx();
    test_console_rx();
    test_unmapped();
    $display("checks %0d errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* all.f */
hw/bus_pkg.sv
hw/periph_pkg.sv
hw/bus_arbiter.sv
hw/bus_decoder.sv
hw/clint_timer.sv
hw/uart_console.sv
hw/data_ram.sv
hw/periph_soc.sv
verification/periph_soc_assert.sv
verification/tb_periph_soc.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_periph_soc
BUILD_DIR ?= obj_dir
FILELIST  ?= all.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(wildcard hw/*.sv) $(wildcard verification/*.sv)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf $(BUILD_DIR)
